/* hw/sysmon_pkg.sv */
// System monitor shared definitions
`default_nettype none

package sysmon_pkg;

    localparam int VOLT_W         = 14;
    localparam int VOTE_W         = 11;
    localparam int BRIGHT_MAX     = 15;
    localparam int HISTORY_LEN    = 16;
    localparam int PWM_PERIOD     = 256;
    localparam int PWM_W          = $clog2(PWM_PERIOD);
    localparam int SETTLE_SAMPLES = 512;
    localparam int VOTE_LIMIT     = 127;
    localparam int AVG_SAMPLES    = 256;
    localparam int AVG_SHIFT      = $clog2(AVG_SAMPLES);
    localparam int SUM_W          = VOLT_W + AVG_SHIFT;
    localparam int VOLT_VALID     = 700;   // About 1.8 V
    localparam int LED_ON_SECONDS = 5;
    localparam int SECOND_MAX     = 7;

    localparam int DEFAULT_ADC_INTERVAL = 41946;   // 5 ms at 8.39 MHz
    localparam int DEFAULT_MUX_LEAD     = 1000;

    typedef logic [VOLT_W-1:0]        volt_t;
    typedef logic [3:0]               brightness_t;
    typedef logic signed [VOTE_W-1:0] vote_t;

    typedef struct packed {
        logic menu_n;   // Pressed = 0
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic sel;
        logic start;
    } buttons_t;

    typedef struct packed {
        logic  is_lithium;
        logic  type_known;
        volt_t volt;
    } battery_status_t;

    typedef enum logic [1:0] {
        PHASE_SETTLE,
        PHASE_DETECT,
        PHASE_AVERAGE
    } meter_phase_t;

    typedef enum logic {
        MENU_IDLE,
        MENU_HELD
    } menu_state_t;

    // One sample of one level, then fifteen of the other
    localparam logic [HISTORY_LEN-1:0] HIST_PRESS   = {1'b1, {(HISTORY_LEN-1){1'b0}}};
    localparam logic [HISTORY_LEN-1:0] HIST_RELEASE = ~HIST_PRESS;

    localparam volt_t LI_FULL   = 14'd1423;   // 3.75 V
    localparam volt_t LI_CRIT   = 14'd1145;
    localparam volt_t LI_RED    = 14'd1182;
    localparam volt_t LI_YELLOW = 14'd1293;
    localparam volt_t AA_FULL   = 14'd1367;   // 3.6 V
    localparam volt_t AA_CRIT   = 14'd997;
    localparam volt_t AA_RED    = 14'd1071;
    localparam volt_t AA_YELLOW = 14'd1200;

    localparam volt_t AA_DIM_BELOW = 14'd979;    // 2.55 V
    localparam volt_t AA_DIM_ABOVE = 14'd1293;   // 3.4 V

endpackage

`default_nettype wire

/* hw/button_sync.sv */
// Button synchronizers and menu control
`timescale 1ns/1ps
`default_nettype none

module button_sync import sysmon_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       buttons_t buttons,
    output logic      menu_disabled,
    output logic      bright_up,
    output logic      bright_down
);

    buttons_t               sync1;
    buttons_t               sync2;
    logic [HISTORY_LEN-1:0] menu_hist;
    logic [HISTORY_LEN-1:0] left_hist;
    logic [HISTORY_LEN-1:0] right_hist;
    menu_state_t            state;
    logic                   other_btn;

    assign other_btn = sync2.up | sync2.down | sync2.left | sync2.right |
                       sync2.a | sync2.b | sync2.sel | sync2.start;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync1        <= '0;
            sync1.menu_n <= 1'b1;   // Released
            sync2        <= '0;
            sync2.menu_n <= 1'b1;
            menu_hist    <= '1;
            left_hist    <= '0;
            right_hist   <= '0;
        end else begin
            sync1      <= buttons;
            sync2      <= sync1;
            menu_hist  <= {menu_hist[HISTORY_LEN-2:0], sync2.menu_n};
            left_hist  <= {left_hist[HISTORY_LEN-2:0], sync2.left};
            right_hist <= {right_hist[HISTORY_LEN-2:0], sync2.right};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= MENU_IDLE;
            menu_disabled <= 1'b1;
        end else begin
            case (state)
                MENU_IDLE: if (menu_hist == HIST_PRESS) state <= MENU_HELD;
                MENU_HELD: begin
                    if (menu_hist == HIST_RELEASE) begin
                        menu_disabled <= ~menu_disabled;
                        state         <= MENU_IDLE;
                    end
                end
                default: state <= MENU_IDLE;
            endcase
            if (other_btn) state <= MENU_IDLE;   // Combo press, no toggle
        end
    end

    // Steps only while menu held in normal mode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bright_up   <= 1'b0;
            bright_down <= 1'b0;
        end else begin
            bright_up   <= menu_disabled && !sync2.menu_n && (right_hist == HIST_PRESS);
            bright_down <= menu_disabled && !sync2.menu_n && (left_hist == HIST_PRESS);
        end
    end

endmodule

`default_nettype wire

/* hw/backlight_ctrl.sv */
// LCD backlight control
`timescale 1ns/1ps
`default_nettype none

module backlight_ctrl import sysmon_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             bright_up,
    input  wire             bright_down,
    input  wire             half_second_tick,
    input  wire             battery_status_t battery_status,
    output logic            lcd_pwm,
    output logic            lcd_backlight_init
);

    brightness_t      brightness;
    brightness_t      saved_brightness;
    logic             dimmed;
    logic             aa_cell;
    logic             volt_ok;
    logic             dim_start;
    logic             dim_end;
    logic [PWM_W-1:0] pwm_cnt;

    assign aa_cell   = battery_status.type_known && !battery_status.is_lithium;
    assign volt_ok   = aa_cell && (battery_status.volt >= VOLT_VALID);
    assign dim_start = volt_ok && !dimmed && (battery_status.volt < AA_DIM_BELOW);
    assign dim_end   = volt_ok && dimmed && (battery_status.volt > AA_DIM_ABOVE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            brightness <= '0;
            dimmed     <= 1'b0;
        end else begin
            if (bright_down && brightness != 0)
                brightness <= brightness - 1'b1;
            if (bright_up && brightness != BRIGHT_MAX)
                brightness <= brightness + 1'b1;
            if (dimmed)
                brightness <= '0;   // Held dark on a weak AA cell
            if (dim_start)
                dimmed <= 1'b1;
            if (dim_end) begin
                dimmed     <= 1'b0;
                brightness <= saved_brightness;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dim_start)
            saved_brightness <= brightness;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt            <= '0;
            lcd_backlight_init <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;   // Free running
            if (half_second_tick)
                lcd_backlight_init <= 1'b1;
        end
    end

    assign lcd_pwm = (pwm_cnt <= {brightness, 4'b0000});

endmodule

`default_nettype wire

/* hw/battery_meter.sv */
// Battery voltage meter
`timescale 1ns/1ps
`default_nettype none

module battery_meter import sysmon_pkg::*; #(
    parameter int ADC_INTERVAL = DEFAULT_ADC_INTERVAL,
    parameter int MUX_LEAD     = DEFAULT_MUX_LEAD
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  adc_ready,
    input  wire                  volt_t adc_value,
    output logic                 adc_req,
    output logic                 adc_sel,
    output battery_status_t      battery_status
);

    localparam int TIMER_W = $clog2(ADC_INTERVAL + 1);

    logic [TIMER_W-1:0]                timer;
    logic                              mux_toggle;
    meter_phase_t                      phase;
    logic [$clog2(SETTLE_SAMPLES)-1:0] settle_cnt;
    vote_t                             vote;
    logic                              is_lithium;
    logic                              type_known;
    logic [AVG_SHIFT-1:0]              avg_cnt;
    logic [SUM_W-1:0]                  sum;
    logic [SUM_W-1:0]                  sum_next;
    logic                              last_sample;
    volt_t                             volt;

    assign type_known  = (phase == PHASE_AVERAGE);
    assign sum_next    = sum + SUM_W'(adc_value);
    assign last_sample = type_known && (&avg_cnt);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer      <= '0;
            adc_req    <= 1'b0;
            mux_toggle <= 1'b0;
        end else if (timer < ADC_INTERVAL) begin
            timer   <= timer + 1'b1;
            adc_req <= 1'b0;
            // Switch the mux ahead of the next conversion
            if (!type_known && timer == ADC_INTERVAL - MUX_LEAD)
                mux_toggle <= ~mux_toggle;
        end else begin
            timer   <= '0;
            adc_req <= 1'b1;
        end
    end

    assign adc_sel = type_known ? is_lithium : mux_toggle;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= PHASE_SETTLE;
            settle_cnt <= '0;
            vote       <= '0;
            is_lithium <= 1'b0;
            avg_cnt    <= '0;
            volt       <= '0;
        end else if (adc_ready) begin
            case (phase)
                PHASE_SETTLE: begin
                    settle_cnt <= settle_cnt + 1'b1;
                    if (&settle_cnt)
                        phase <= PHASE_DETECT;
                end
                PHASE_DETECT: begin
                    if (vote > VOTE_LIMIT || vote < -VOTE_LIMIT) begin
                        phase      <= PHASE_AVERAGE;
                        is_lithium <= vote[VOTE_W-1];   // Negative means lithium
                    end else if (adc_value >= VOLT_VALID) begin
                        vote <= adc_sel ? vote - vote_t'(1) : vote + vote_t'(1);
                    end
                end
                PHASE_AVERAGE: begin
                    avg_cnt <= avg_cnt + 1'b1;
                    if (last_sample)
                        volt <= sum_next[SUM_W-1:AVG_SHIFT];
                end
                default: phase <= PHASE_SETTLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (adc_ready) begin
            if (phase == PHASE_DETECT || last_sample)
                sum <= '0;   // Start of a new window
            else if (type_known)
                sum <= sum_next;
        end
    end

    assign battery_status = {is_lithium, type_known, volt};

endmodule

`default_nettype wire

/* hw/battery_leds.sv */
// Battery status LEDs
`timescale 1ns/1ps
`default_nettype none

module battery_leds import sysmon_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        battery_status_t battery_status,
    input  wire        charging,
    input  wire        second_tick,
    output logic       led_red,
    output logic       led_yellow,
    output logic       led_green,
    output logic       low_battery
);

    volt_t      volt;
    volt_t      full_th;
    volt_t      crit_th;
    volt_t      red_th;
    volt_t      yellow_th;
    logic       blink;
    logic       discharge_first;
    logic       was_green;
    logic [2:0] second_cnt;
    logic       show_level;

    assign volt       = battery_status.volt;
    assign full_th    = battery_status.is_lithium ? LI_FULL : AA_FULL;
    assign crit_th    = battery_status.is_lithium ? LI_CRIT : AA_CRIT;
    assign red_th     = battery_status.is_lithium ? LI_RED : AA_RED;
    assign yellow_th  = battery_status.is_lithium ? LI_YELLOW : AA_YELLOW;
    assign show_level = (second_cnt < LED_ON_SECONDS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            led_red         <= 1'b0;
            led_yellow      <= 1'b0;
            led_green       <= 1'b0;
            low_battery     <= 1'b0;
            blink           <= 1'b0;
            discharge_first <= 1'b1;
            was_green       <= 1'b0;
            second_cnt      <= '0;
        end else begin
            if (second_tick)
                blink <= ~blink;
            led_red     <= 1'b0;
            led_yellow  <= 1'b0;
            led_green   <= 1'b0;
            low_battery <= 1'b0;
            was_green   <= 1'b0;
            if (volt >= VOLT_VALID) begin
                if (charging) begin
                    discharge_first <= 1'b1;
                    led_green       <= (volt >= full_th) || blink;   // Blinks until full
                end else begin
                    discharge_first <= 1'b0;
                    if (volt < crit_th) begin
                        low_battery <= 1'b1;
                        led_red     <= blink;
                    end else if (volt < red_th) begin
                        low_battery <= 1'b1;
                        led_red     <= 1'b1;
                    end else if (volt < yellow_th) begin
                        led_yellow <= show_level;
                        if (was_green)
                            discharge_first <= 1'b1;   // Dropped out of green
                    end else begin
                        led_green <= show_level;
                        was_green <= 1'b1;
                    end
                    if (discharge_first)
                        second_cnt <= '0;
                    else if (second_tick && second_cnt < SECOND_MAX)
                        second_cnt <= second_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/system_monitor.sv */
// System monitor top level
`timescale 1ns/1ps
`default_nettype none

module system_monitor import sysmon_pkg::*; #(
    parameter int ADC_INTERVAL = DEFAULT_ADC_INTERVAL,
    parameter int MUX_LEAD     = DEFAULT_MUX_LEAD
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  buttons_t buttons,
    input  wire                  adc_ready,
    input  wire                  volt_t adc_value,
    input  wire                  charging,
    input  wire                  second_tick,
    input  wire                  half_second_tick,
    output logic                 adc_req,
    output logic                 adc_sel,
    output logic                 lcd_pwm,
    output logic                 lcd_backlight_init,
    output logic                 menu_disabled,
    output logic                 led_red,
    output logic                 led_yellow,
    output logic                 led_green,
    output logic                 low_battery,
    output battery_status_t      battery_status
);

    logic bright_up;
    logic bright_down;

    button_sync u_button_sync (
        .clk           (clk),
        .reset         (reset),
        .buttons       (buttons),
        .menu_disabled (menu_disabled),
        .bright_up     (bright_up),
        .bright_down   (bright_down)
    );

    backlight_ctrl u_backlight_ctrl (
        .clk                (clk),
        .reset              (reset),
        .bright_up          (bright_up),
        .bright_down        (bright_down),
        .half_second_tick   (half_second_tick),
        .battery_status     (battery_status),
        .lcd_pwm            (lcd_pwm),
        .lcd_backlight_init (lcd_backlight_init)
    );

    battery_meter #(
        .ADC_INTERVAL (ADC_INTERVAL),
        .MUX_LEAD     (MUX_LEAD)
    ) u_battery_meter (
        .clk            (clk),
        .reset          (reset),
        .adc_ready      (adc_ready),
        .adc_value      (adc_value),
        .adc_req        (adc_req),
        .adc_sel        (adc_sel),
        .battery_status (battery_status)
    );

    battery_leds u_battery_leds (
        .clk            (clk),
        .reset          (reset),
        .battery_status (battery_status),
        .charging       (charging),
        .second_tick    (second_tick),
        .led_red        (led_red),
        .led_yellow     (led_yellow),
        .led_green      (led_green),
        .low_battery    (low_battery)
    );

endmodule

`default_nettype wire

/* verification/system_monitor_asserts.sv */
// System monitor assertions
`timescale 1ns/1ps
`default_nettype none

module system_monitor_asserts import sysmon_pkg::*; (
    input wire                  clk,
    input wire                  reset,
    input wire                  adc_req,
    input wire                  adc_sel,
    input wire                  led_red,
    input wire                  led_yellow,
    input wire                  led_green,
    input wire battery_status_t battery_status
);

    a_req_single: assert property (@(posedge clk) disable iff (reset)
        adc_req |=> !adc_req)
        else $error("adc_req high for two cycles");

    a_leds_dark: assert property (@(posedge clk) disable iff (reset)
        (battery_status.volt < VOLT_VALID) |=> !(led_red || led_yellow || led_green))
        else $error("LED lit without a valid voltage");

    a_red_green: assert property (@(posedge clk) disable iff (reset)
        !(led_red && led_green))
        else $error("Red and green LEDs lit together");

    // Detected cell stays fixed and keeps the mux
    a_sel_locked: assert property (@(posedge clk) disable iff (reset)
        battery_status.type_known |=> battery_status.type_known &&
            $stable(battery_status.is_lithium) && (adc_sel == battery_status.is_lithium))
        else $error("Cell type or adc_sel changed after detection");

endmodule

bind system_monitor system_monitor_asserts u_system_monitor_asserts (.*);

`default_nettype wire

/* verification/tb_system_monitor.sv */
// System monitor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_system_monitor import sysmon_pkg::*; ();

    localparam int ADC_INTERVAL = 64;
    localparam int MUX_LEAD     = 8;

    logic            clk;
    logic            reset;
    buttons_t        buttons;
    logic            adc_ready;
    volt_t           adc_value;
    logic            charging;
    logic            second_tick;
    logic            half_second_tick;
    logic            adc_req;
    logic            adc_sel;
    logic            lcd_pwm;
    logic            lcd_backlight_init;
    logic            menu_disabled;
    logic            led_red;
    logic            led_yellow;
    logic            led_green;
    logic            low_battery;
    battery_status_t battery_status;

    integer      seed;
    int          errors;
    logic        cell_li;        // Cell under test
    int          adc_level;
    int          ready_delay;
    int          req_gap;
    logic        req_seen;
    int          avg_cnt;
    int          avg_sum;
    logic        avg_pending;
    volt_t       avg_expected;
    int          windows_done;
    volt_t       model_volt;
    brightness_t model_bright;
    brightness_t saved_bright;
    logic        model_dimmed;
    logic        model_menu_dis;
    logic        m_red;
    logic        m_yellow;
    logic        m_green;
    logic        m_low;
    logic        m_blink;
    logic        m_first;
    logic        m_was_green;
    logic        m_init;
    logic [2:0]  m_sec;
    volt_t       th_full;
    volt_t       th_crit;
    volt_t       th_red;
    volt_t       th_yellow;

    assign th_full   = cell_li ? LI_FULL : AA_FULL;
    assign th_crit   = cell_li ? LI_CRIT : AA_CRIT;
    assign th_red    = cell_li ? LI_RED : AA_RED;
    assign th_yellow = cell_li ? LI_YELLOW : AA_YELLOW;

    system_monitor #(
        .ADC_INTERVAL (ADC_INTERVAL),
        .MUX_LEAD     (MUX_LEAD)
    ) u_system_monitor (
        .clk                (clk),
        .reset              (reset),
        .buttons            (buttons),
        .adc_ready          (adc_ready),
        .adc_value          (adc_value),
        .charging           (charging),
        .second_tick        (second_tick),
        .half_second_tick   (half_second_tick),
        .adc_req            (adc_req),
        .adc_sel            (adc_sel),
        .lcd_pwm            (lcd_pwm),
        .lcd_backlight_init (lcd_backlight_init),
        .menu_disabled      (menu_disabled),
        .led_red            (led_red),
        .led_yellow         (led_yellow),
        .led_green          (led_green),
        .low_battery        (low_battery),
        .battery_status     (battery_status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        errors++;
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_volt(input string name, input volt_t got, input volt_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_brightness(input brightness_t got, input brightness_t exp);
        if (got !== exp) begin
            $display("Error at %0t: brightness is %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    // Status LED and init flag model
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_red       <= 1'b0;
            m_yellow    <= 1'b0;
            m_green     <= 1'b0;
            m_low       <= 1'b0;
            m_blink     <= 1'b0;
            m_first     <= 1'b1;
            m_was_green <= 1'b0;
            m_sec       <= '0;
            m_init      <= 1'b0;
        end else begin
            if (half_second_tick)
                m_init <= 1'b1;
            if (second_tick)
                m_blink <= ~m_blink;
            m_red       <= 1'b0;
            m_yellow    <= 1'b0;
            m_green     <= 1'b0;
            m_low       <= 1'b0;
            m_was_green <= 1'b0;
            if (model_volt >= VOLT_VALID && charging) begin
                m_first <= 1'b1;
                m_green <= (model_volt >= th_full) || m_blink;
            end else if (model_volt >= VOLT_VALID) begin
                m_first <= 1'b0;
                if (model_volt < th_crit) begin
                    m_low <= 1'b1;
                    m_red <= m_blink;
                end else if (model_volt < th_red) begin
                    m_low <= 1'b1;
                    m_red <= 1'b1;
                end else if (model_volt < th_yellow) begin
                    m_yellow <= (m_sec < 3'd5);
                    if (m_was_green)
                        m_first <= 1'b1;
                end else begin
                    m_green     <= (m_sec < 3'd5);
                    m_was_green <= 1'b1;
                end
                if (m_first)
                    m_sec <= '0;
                else if (second_tick && m_sec != 3'd7)
                    m_sec <= m_sec + 1'b1;
            end
        end
    end

    task automatic track_dimming();
        if (!cell_li && model_volt >= VOLT_VALID) begin
            if (model_volt < AA_DIM_BELOW && !model_dimmed) begin
                saved_bright = model_bright;
                model_bright = '0;
                model_dimmed = 1'b1;
            end else if (model_volt > AA_DIM_ABOVE && model_dimmed) begin
                model_bright = saved_bright;
                model_dimmed = 1'b0;
            end
        end
    endtask

    // ADC answer folded into the running average
    task automatic drive_sample();
        volt_t value;
        if (battery_status.type_known || adc_sel == cell_li)
            value = volt_t'(adc_level + int'($unsigned($random(seed)) % 8));
        else
            value = volt_t'($unsigned($random(seed)) % VOLT_VALID);   // Wrong path
        adc_value = value;
        adc_ready = 1'b1;
        if (battery_status.type_known) begin
            avg_sum += value;
            avg_cnt++;
            if (avg_cnt == AVG_SAMPLES) begin
                avg_expected = volt_t'(avg_sum / AVG_SAMPLES);
                avg_pending  = 1'b1;
                avg_sum      = 0;
                avg_cnt      = 0;
            end
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            adc_ready   = 1'b0;
            ready_delay = 0;
            req_gap     = 0;
            req_seen    = 1'b0;
            avg_cnt     = 0;
            avg_sum     = 0;
            avg_pending = 1'b0;
            model_volt  = '0;
        end else begin
            if (avg_pending) begin
                check_volt("volt", battery_status.volt, avg_expected);
                model_volt  = avg_expected;
                avg_pending = 1'b0;
                track_dimming();
                windows_done++;
            end
            check_bit("led_red", led_red, m_red);
            check_bit("led_yellow", led_yellow, m_yellow);
            check_bit("led_green", led_green, m_green);
            check_bit("low_battery", low_battery, m_low);
            check_bit("lcd_backlight_init", lcd_backlight_init, m_init);
            if (battery_status.type_known)
                check_bit("adc_sel", adc_sel, cell_li);
            req_gap++;
            if (req_seen)
                check_bit("adc_req", adc_req, req_gap == ADC_INTERVAL + 1);
            if (adc_req) begin
                req_gap  = 0;
                req_seen = 1'b1;
            end
            adc_ready = 1'b0;
            if (ready_delay > 0) begin
                ready_delay--;
                if (ready_delay == 0)
                    drive_sample();
            end
            if (adc_req)
                ready_delay = 1 + int'($unsigned($random(seed)) % 10);
        end
        second_tick      = ($unsigned($random(seed)) % 32) == 0;
        half_second_tick = ($unsigned($random(seed)) % 32) == 0;
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic menu_press(input logic with_other);
        int pick;
        buttons.menu_n = 1'b0;
        idle_cycles(24);
        if (with_other) begin
            pick          = $unsigned($random(seed)) % 8;
            buttons[pick] = 1'b1;   // Any of up to start
            idle_cycles(2);
            buttons[pick] = 1'b0;
        end
        idle_cycles(24);
        buttons.menu_n = 1'b1;
        idle_cycles(24);
        if (!with_other)
            model_menu_dis = ~model_menu_dis;
        check_bit("menu_disabled", menu_disabled, model_menu_dis);
    endtask

    task automatic measure_brightness(output brightness_t level);
        int high;
        high = 0;
        idle_cycles(3);
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            if (lcd_pwm)
                high++;
        end
        level = brightness_t'((high - 1) / 16);
    endtask

    task automatic step_brightness(input int presses);
        int          i;
        logic        go_up;
        brightness_t level;
        buttons.menu_n = 1'b0;
        idle_cycles(24);
        for (i = 0; i < presses; i++) begin
            if (i == 0)
                go_up = 1'b0;   // Pushes against the floor
            else if (i <= BRIGHT_MAX + 1)
                go_up = 1'b1;   // Climbs into the ceiling
            else
                go_up = ($unsigned($random(seed)) % 2) != 0;
            if (go_up)
                buttons.right = 1'b1;
            else
                buttons.left = 1'b1;
            idle_cycles(1 + int'($unsigned($random(seed)) % 4));
            buttons.right = 1'b0;
            buttons.left  = 1'b0;
            idle_cycles(24);
            if (go_up && model_bright != BRIGHT_MAX)
                model_bright++;
            else if (!go_up && model_bright != 0)
                model_bright--;
            measure_brightness(level);
            check_brightness(level, model_bright);
        end
        buttons.menu_n = 1'b1;
        idle_cycles(24);
    endtask

    task automatic wait_type_known();
        int cycles;
        cycles = 0;
        while (!battery_status.type_known) begin
            @(negedge clk);
            cycles++;
            if (cycles > 80000) begin
                $display("Timeout: cell type was never detected");
                stop_run();
            end
        end
    endtask

    // Holds a level for one full averaging window
    task automatic apply_level(input int level);
        int target;
        int cycles;
        target    = windows_done + 1;
        adc_level = level;
        cycles    = 0;
        while (windows_done < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20000) begin
                $display("Timeout: averaged voltage did not update");
                stop_run();
            end
        end
    endtask

    task automatic run_pass(input logic li);
        int          th [4];
        brightness_t level;
        cell_li        = li;
        adc_level      = 1100 + int'($unsigned($random(seed)) % 300);
        reset          = 1'b1;
        model_bright   = '0;
        model_dimmed   = 1'b0;
        model_menu_dis = 1'b1;
        idle_cycles(3);
        reset = 1'b0;
        menu_press(1'b0);
        menu_press(1'b1);
        menu_press(1'b0);
        step_brightness(24);
        wait_type_known();
        check_bit("is_lithium", battery_status.is_lithium, cell_li);
        th[0] = th_full;
        th[1] = th_crit;
        th[2] = th_red;
        th[3] = th_yellow;
        foreach (th[i]) begin
            charging = $unsigned($random(seed)) % 2;
            apply_level(th[i] - 12 + int'($unsigned($random(seed)) % 24));
        end
        apply_level(600 + int'($unsigned($random(seed)) % 90));   // Not a valid reading
        if (!cell_li) begin
            apply_level(900 + int'($unsigned($random(seed)) % 60));
            measure_brightness(level);
            check_brightness(level, model_bright);
            apply_level(1310 + int'($unsigned($random(seed)) % 80));
            measure_brightness(level);
            check_brightness(level, model_bright);
        end
    endtask

    initial begin
        logic first_cell;
        seed             = 32'h1e09;
        errors           = 0;
        windows_done     = 0;
        reset            = 1'b1;
        buttons          = '0;
        buttons.menu_n   = 1'b1;
        adc_ready        = 1'b0;
        adc_value        = '0;
        charging         = 1'b0;
        second_tick      = 1'b0;
        half_second_tick = 1'b0;
        model_volt       = '0;
        cell_li          = 1'b0;
        first_cell       = $unsigned($random(seed)) % 2;
        run_pass(first_cell);
        run_pass(!first_cell);   // Other cell type after a fresh reset
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/sysmon_pkg.sv
hw/button_sync.sv
hw/backlight_ctrl.sv
hw/battery_meter.sv
hw/battery_leds.sv
hw/system_monitor.sv
verification/system_monitor_asserts.sv
verification/tb_system_monitor.sv
